// ==== source/bridge_config.svh ====
/*
 * Bridge configuration
 * Address map, timer count and interrupt vector width for the
 * device-side bus of the south bridge
 */
`ifndef BRIDGE_CONFIG_SVH
`define BRIDGE_CONFIG_SVH

// Number of timers hanging off the bridge, 1 to 4
`define NUM_TIMERS 2

// Byte address of timer 0
`define TIMER_BASE 32'h0000_7F00

// Byte window of one timer, four words
`define TIMER_STRIDE 16

// Bytes covered by all timer windows together
`define TIMER_SPAN (`NUM_TIMERS * `TIMER_STRIDE)

// Hardware interrupt lines 7 to 2 of the CPU
`define HW_INT_WIDTH 6

`endif

// ==== source/bridgePkg.sv ====
/*
 * Bridge types
 * Register index inside a timer window and the timer control word
 */
package bridgePkg;

    // Word index inside one timer window
    typedef enum logic [1:0] {
        REG_CTRL   = 2'd0,
        REG_PRESET = 2'd1,
        REG_COUNT  = 2'd2,
        REG_NONE   = 2'd3
    } regIndex_t;

    // Control fields, enable in bit 0
    typedef struct packed {
        logic [28:0] reserved;
        logic        irqMask;
        logic        autoReload;
        logic        enable;
    } timerFields_t;

    // Same word seen as bus data or as control fields
    typedef union packed {
        logic [31:0]  raw;
        timerFields_t fields;
    } timerCtrl_t;

endpackage

// ==== source/apbDecoder.sv ====
/*
 * APB address decoder
 * Maps a byte address onto one timer and one register inside it,
 * flags accesses outside the windows and partial writes
 */
`timescale 1ns/1ps
`include "bridge_config.svh"

module apbDecoder (
    input  logic                       psel,
    input  logic [31:0]                paddr,
    input  logic                       pwrite,
    input  logic [3:0]                 pstrb,
    output logic [`NUM_TIMERS-1:0]     timerSel,
    output bridgePkg::regIndex_t       regIndex,
    output logic                       decodeErr
);

    localparam int unsigned SPAN = `TIMER_SPAN;

    logic [31:0] offset;
    logic [31:0] timerIdx;
    logic        outOfRange;
    logic        partialWrite;

    always_comb begin
        // Addresses below the base wrap around and fail the range test
        offset       = paddr - `TIMER_BASE;
        timerIdx     = offset / `TIMER_STRIDE;
        regIndex     = bridgePkg::regIndex_t'(offset[3:2]);
        outOfRange   = offset >= SPAN;
        // Devices only take whole words
        partialWrite = pwrite && (pstrb != 4'b1111);

        timerSel  = '0;
        decodeErr = 1'b0;
        if (psel) begin
            decodeErr = outOfRange || (regIndex == bridgePkg::REG_NONE) || partialWrite;
            for (int i = 0; i < `NUM_TIMERS; i++) begin
                timerSel[i] = !decodeErr && (timerIdx == i);
            end
        end

        // An access either reaches exactly one device or is flagged
        assert (!psel || (decodeErr ? (timerSel == '0) : $onehot(timerSel)))
            else $error("apbDecoder: bad select %b with err %b", timerSel, decodeErr);
    end

endmodule

// ==== source/devTimer.sv ====
/*
 * Programmable timer
 * Down-counter with preset, control word, one-shot or auto-reload
 * mode and a maskable interrupt
 */
`timescale 1ns/1ps

module devTimer (
    input  logic                 clk,
    input  logic                 rstN,
    input  logic                 sel,
    input  logic                 penable,
    input  logic                 pwrite,
    input  bridgePkg::regIndex_t regIndex,
    input  logic [31:0]          pwdata,
    output logic [31:0]          rdata,
    output logic                 irq
);

    bridgePkg::timerCtrl_t ctrl;
    bridgePkg::timerCtrl_t wrCtrl;
    logic [31:0]           preset;
    logic [31:0]           count;
    logic                  pending;
    // Preset changed since count was last loaded from it
    logic                  presetDirty;
    logic                  wrEn;

    // Write lands at the end of the access phase
    assign wrEn       = sel && penable && pwrite;
    assign wrCtrl.raw = pwdata;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            ctrl        <= '0;
            preset      <= '0;
            count       <= '0;
            pending     <= 1'b0;
            presetDirty <= 1'b0;
        end else if (wrEn && (regIndex == bridgePkg::REG_CTRL)) begin
            ctrl    <= wrCtrl;
            pending <= 1'b0;
            if (wrCtrl.fields.enable) begin
                count       <= preset;
                presetDirty <= 1'b0;
            end
        end else begin
            if (ctrl.fields.enable) begin
                if (count == 32'd1) begin
                    count   <= '0;
                    pending <= 1'b1;
                    // One-shot stops here
                    if (!ctrl.fields.autoReload) begin
                        ctrl.fields.enable <= 1'b0;
                    end
                end else if (count != '0) begin
                    count <= count - 32'd1;
                end else if (ctrl.fields.autoReload) begin
                    // Reload one cycle after reaching zero
                    count       <= preset;
                    presetDirty <= 1'b0;
                end
            end
            // Kept after the reload so a same-cycle preset write stays marked
            if (wrEn && (regIndex == bridgePkg::REG_PRESET)) begin
                preset      <= pwdata;
                presetDirty <= 1'b1;
            end
        end
    end

    always_comb begin
        case (regIndex)
            bridgePkg::REG_CTRL:   rdata = ctrl.raw;
            bridgePkg::REG_PRESET: rdata = preset;
            bridgePkg::REG_COUNT:  rdata = count;
            default:               rdata = '0;
        endcase
    end

    assign irq = pending && ctrl.fields.irqMask;

    // Running count stays within the preset it was loaded from
    assert property (@(posedge clk) disable iff (!rstN)
        (ctrl.fields.enable && !presetDirty) |-> (count <= preset))
        else $error("devTimer: count %0d above preset %0d", count, preset);

endmodule

// ==== source/returnMerge.sv ====
/*
 * Return path merge
 * Selects timer read data, forms the APB response and registers
 * the hardware interrupt vector
 */
`timescale 1ns/1ps
`include "bridge_config.svh"

module returnMerge (
    input  logic                               clk,
    input  logic                               rstN,
    input  logic                               psel,
    input  logic                               penable,
    input  logic [`NUM_TIMERS-1:0]             timerSel,
    input  logic                               decodeErr,
    input  logic [`NUM_TIMERS-1:0][31:0]       timerRdata,
    input  logic [`NUM_TIMERS-1:0]             timerIrq,
    input  logic                               extInt,
    output logic [31:0]                        prdata,
    output logic                               pready,
    output logic                               pslverr,
    output logic [`HW_INT_WIDTH-1:0]           hwInt
);

    logic [`HW_INT_WIDTH-1:0] hwIntNext;

    // No wait states, every access phase completes
    assign pready  = psel && penable;
    assign pslverr = pready && decodeErr;

    // One-hot select, so an OR of masked words is enough
    always_comb begin
        prdata = '0;
        for (int i = 0; i < `NUM_TIMERS; i++) begin
            prdata = prdata | (timerRdata[i] & {32{timerSel[i]}});
        end
    end

    // Timers first, external line right above them
    always_comb begin
        hwIntNext                = '0;
        hwIntNext[`NUM_TIMERS-1:0] = timerIrq;
        hwIntNext[`NUM_TIMERS]   = extInt;
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            hwInt <= '0;
        end else begin
            hwInt <= hwIntNext;
        end
    end

    // Error only closes a transfer that went through its setup phase
    assert property (@(posedge clk) disable iff (!rstN)
        pslverr |-> (pready && $past(psel && !penable)))
        else $error("returnMerge: pslverr outside a proper access phase");

endmodule

// ==== source/southBridge.sv ====
/*
 * South bridge
 * APB completer for the device side, decodes each access onto a
 * bank of timers and merges their replies and interrupts
 */
`timescale 1ns/1ps
`include "bridge_config.svh"

module southBridge (
    input  logic                     clk,
    input  logic                     rstN,
    input  logic                     psel,
    input  logic                     penable,
    input  logic                     pwrite,
    input  logic [31:0]              paddr,
    input  logic [31:0]              pwdata,
    input  logic [3:0]               pstrb,
    output logic [31:0]              prdata,
    output logic                     pready,
    output logic                     pslverr,
    input  logic                     extInt,
    output logic [`HW_INT_WIDTH-1:0] hwInt
);

    logic [`NUM_TIMERS-1:0]       timerSel;
    bridgePkg::regIndex_t         regIndex;
    logic                         decodeErr;
    logic [`NUM_TIMERS-1:0][31:0] timerRdata;
    logic [`NUM_TIMERS-1:0]       timerIrq;

    apbDecoder i_decoder (
        .psel      (psel),
        .paddr     (paddr),
        .pwrite    (pwrite),
        .pstrb     (pstrb),
        .timerSel  (timerSel),
        .regIndex  (regIndex),
        .decodeErr (decodeErr)
    );

    // One APB link per timer, only the select differs
    for (genvar i = 0; i < `NUM_TIMERS; i++) begin : g_timer
        devTimer i_timer (
            .clk      (clk),
            .rstN     (rstN),
            .sel      (timerSel[i]),
            .penable  (penable),
            .pwrite   (pwrite),
            .regIndex (regIndex),
            .pwdata   (pwdata),
            .rdata    (timerRdata[i]),
            .irq      (timerIrq[i])
        );
    end

    returnMerge i_merge (
        .clk        (clk),
        .rstN       (rstN),
        .psel       (psel),
        .penable    (penable),
        .timerSel   (timerSel),
        .decodeErr  (decodeErr),
        .timerRdata (timerRdata),
        .timerIrq   (timerIrq),
        .extInt     (extInt),
        .prdata     (prdata),
        .pready     (pready),
        .pslverr    (pslverr),
        .hwInt      (hwInt)
    );

endmodule

// ==== tb/tbSouthBridge.sv ====
/*
 * South bridge testbench
 * Table-driven register checks over APB, then one-shot, reload,
 * masked and external interrupt scenarios
 */
`timescale 1ns/1ps
`include "bridge_config.svh"

module tbSouthBridge;

    localparam int TIMEOUT = 500;

    typedef enum logic {OP_READ, OP_WRITE} opKind_t;

    typedef struct {
        opKind_t     op;
        logic [31:0] addr;
        logic [31:0] data;
        logic [3:0]  strb;
        logic [31:0] expData;
        logic        expErr;
    } step_t;

    logic                     clk;
    logic                     rstN;
    logic                     psel;
    logic                     penable;
    logic                     pwrite;
    logic [31:0]              paddr;
    logic [31:0]              pwdata;
    logic [3:0]               pstrb;
    logic [31:0]              prdata;
    logic                     pready;
    logic                     pslverr;
    logic                     extInt;
    logic [`HW_INT_WIDTH-1:0] hwInt;

    step_t       steps[$];
    logic [31:0] lfsrState;

    southBridge i_dut (
        .clk     (clk),
        .rstN    (rstN),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .pstrb   (pstrb),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .extInt  (extInt),
        .hwInt   (hwInt)
    );

    always #20 clk = ~clk;

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsrStep(logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] randBits(int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsrState = lfsrStep(lfsrState);
            v = {v[30:0], lfsrState[0]};
        end
        return v;
    endfunction

    function automatic logic [31:0] makeCtrl(logic en, logic reload, logic mask,
                                             logic [28:0] rsvd);
        bridgePkg::timerCtrl_t c;
        c.fields.reserved   = rsvd;
        c.fields.irqMask    = mask;
        c.fields.autoReload = reload;
        c.fields.enable     = en;
        return c.raw;
    endfunction

    // Word r of timer t
    function automatic logic [31:0] timerAddr(int t, int r);
        return `TIMER_BASE + 32'(t * `TIMER_STRIDE + r * 4);
    endfunction

    function automatic void addStep(opKind_t op, logic [31:0] addr, logic [31:0] data,
                                    logic [3:0] strb, logic [31:0] expData, logic expErr);
        step_t s;
        s.op      = op;
        s.addr    = addr;
        s.data    = data;
        s.strb    = strb;
        s.expData = expData;
        s.expErr  = expErr;
        steps.push_back(s);
    endfunction

    task automatic abortRun();
        $display("=== FAIL ===");
        $fatal(1, "simulation stopped after an error");
    endtask

    task automatic timeoutFail(string what);
        $display("Timeout at %0t: %s did not happen within %0d cycles", $time, what, TIMEOUT);
        abortRun();
    endtask

    task automatic checkEq(string what, logic [31:0] got, logic [31:0] exp);
        if (got !== exp) begin
            $display("[ERROR] %0t: %s, got %h expected %h", $time, what, got, exp);
            abortRun();
        end
    endtask

    task automatic apbTransfer(logic write, logic [31:0] addr, logic [31:0] data,
                               logic [3:0] strb, output logic [31:0] rdata,
                               output logic err);
        int waits;
        @(posedge clk);
        #2;
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = write;
        paddr   = addr;
        pwdata  = data;
        pstrb   = strb;
        @(negedge clk);
        checkEq("pready in setup phase", 32'(pready), 32'd0);
        checkEq("pslverr in setup phase", 32'(pslverr), 32'd0);
        @(posedge clk);
        #2;
        penable = 1'b1;
        waits   = 0;
        @(negedge clk);
        while (!pready) begin
            if (waits >= TIMEOUT) timeoutFail("pready");
            waits++;
            @(negedge clk);
        end
        // No wait states, the access phase completes at once
        checkEq("wait states before pready", 32'(waits), 32'd0);
        rdata = prdata;
        err   = pslverr;
        @(posedge clk);
        #2;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apbWrite(logic [31:0] addr, logic [31:0] data, logic [3:0] strb,
                            output logic err);
        logic [31:0] unused;
        apbTransfer(1'b1, addr, data, strb, unused, err);
    endtask

    task automatic apbRead(logic [31:0] addr, output logic [31:0] rdata, output logic err);
        apbTransfer(1'b0, addr, '0, 4'h0, rdata, err);
    endtask

    task automatic waitHwInt(int idx, logic val, string what);
        int n;
        n = 0;
        while (hwInt[idx] !== val) begin
            if (n >= TIMEOUT) timeoutFail(what);
            n++;
            @(negedge clk);
        end
    endtask

    task automatic buildTable();
        logic [31:0] p;
        logic [31:0] c;
        for (int t = 0; t < `NUM_TIMERS; t++) begin
            p = 32'hA5A5_0000 | 32'(t);
            c = makeCtrl(1'b0, 1'b1, 1'b1, 29'(29'h0ABC_DE0 + t));
            addStep(OP_WRITE, timerAddr(t, 1), p, 4'hF, '0, 1'b0);
            addStep(OP_READ, timerAddr(t, 1), '0, 4'h0, p, 1'b0);
            addStep(OP_WRITE, timerAddr(t, 0), c, 4'hF, '0, 1'b0);
            addStep(OP_READ, timerAddr(t, 0), '0, 4'h0, c, 1'b0);
            addStep(OP_READ, timerAddr(t, 2), '0, 4'h0, '0, 1'b0);
            // Count is read-only, the write is accepted but ignored
            addStep(OP_WRITE, timerAddr(t, 2), 32'h1234_5678, 4'hF, '0, 1'b0);
            addStep(OP_READ, timerAddr(t, 2), '0, 4'h0, '0, 1'b0);
            addStep(OP_READ, timerAddr(t, 3), '0, 4'h0, '0, 1'b1);
            addStep(OP_WRITE, timerAddr(t, 3), 32'hFFFF_FFFF, 4'hF, '0, 1'b1);
            addStep(OP_WRITE, timerAddr(t, 1), 32'hDEAD_BEEF, 4'b0111, '0, 1'b1);
            addStep(OP_READ, timerAddr(t, 1), '0, 4'h0, p, 1'b0);
        end
        addStep(OP_READ, `TIMER_BASE - 32'd4, '0, 4'h0, '0, 1'b1);
        addStep(OP_READ, timerAddr(`NUM_TIMERS, 0), '0, 4'h0, '0, 1'b1);
        addStep(OP_WRITE, timerAddr(`NUM_TIMERS, 1), 32'h0BAD_0BAD, 4'hF, '0, 1'b1);
        addStep(OP_WRITE, 32'h0000_0000, 32'h0BAD_0BAD, 4'hF, '0, 1'b1);
        addStep(OP_READ, timerAddr(0, 1), '0, 4'h0, 32'hA5A5_0000, 1'b0);
    endtask

    initial begin
        logic [31:0] rd;
        logic        err;
        logic [31:0] preset;
        int          n;
        int          tr;
        clk        = 1'b0;
        rstN       = 1'b0;
        psel       = 1'b0;
        penable    = 1'b0;
        pwrite     = 1'b0;
        paddr      = '0;
        pwdata     = '0;
        pstrb      = '0;
        extInt     = 1'b0;
        lfsrState  = 32'h3f82c8e6;
        tr         = `NUM_TIMERS - 1;
        repeat (5) @(posedge clk);
        #2;
        rstN = 1'b1;

        buildTable();
        foreach (steps[i]) begin
            if (steps[i].op == OP_WRITE) begin
                apbWrite(steps[i].addr, steps[i].data, steps[i].strb, err);
            end else begin
                apbRead(steps[i].addr, rd, err);
                checkEq($sformatf("step %0d read data", i), rd, steps[i].expData);
            end
            checkEq($sformatf("step %0d pslverr", i), 32'(err), 32'(steps[i].expErr));
        end

        // One-shot on timer 0, interrupt unmasked
        apbWrite(timerAddr(0, 1), 32'd10, 4'hF, err);
        apbWrite(timerAddr(0, 0), makeCtrl(1'b1, 1'b0, 1'b1, '0), 4'hF, err);
        waitHwInt(0, 1'b1, "one-shot interrupt");
        apbRead(timerAddr(0, 2), rd, err);
        checkEq("one-shot count at expiry", rd, 32'd0);
        apbRead(timerAddr(0, 0), rd, err);
        checkEq("one-shot ctrl after expiry", rd, makeCtrl(1'b0, 1'b0, 1'b1, '0));
        apbWrite(timerAddr(0, 0), makeCtrl(1'b0, 1'b0, 1'b1, '0), 4'hF, err);
        checkEq("hwInt bit still set right after clear", 32'(hwInt[0]), 32'd1);
        @(posedge clk);
        #2;
        checkEq("hwInt one cycle after clear", 32'(hwInt), 32'd0);

        // Reload mode with a small random preset
        preset = randBits(6) + 32'd8;
        apbWrite(timerAddr(tr, 1), preset, 4'hF, err);
        apbWrite(timerAddr(tr, 0), makeCtrl(1'b1, 1'b1, 1'b1, '0), 4'hF, err);
        waitHwInt(tr, 1'b1, "first reload interrupt");
        apbRead(timerAddr(tr, 2), rd, err);
        checkEq("count reloaded after zero", 32'((rd != 0) && (rd <= preset)), 32'd1);
        apbWrite(timerAddr(tr, 0), makeCtrl(1'b1, 1'b1, 1'b1, '0), 4'hF, err);
        @(posedge clk);
        #2;
        checkEq("reload irq after clear", 32'(hwInt[tr]), 32'd0);
        waitHwInt(tr, 1'b1, "second reload interrupt");
        apbWrite(timerAddr(tr, 0), '0, 4'hF, err);
        @(posedge clk);
        #2;
        checkEq("hwInt after reload timer stopped", 32'(hwInt), 32'd0);

        // Masked interrupt, counter still runs out
        apbWrite(timerAddr(0, 1), 32'd6, 4'hF, err);
        apbWrite(timerAddr(0, 0), makeCtrl(1'b1, 1'b0, 1'b0, '0), 4'hF, err);
        n = 0;
        apbRead(timerAddr(0, 2), rd, err);
        while (rd != 32'd0) begin
            if (n >= TIMEOUT) timeoutFail("masked count reaching zero");
            n++;
            apbRead(timerAddr(0, 2), rd, err);
        end
        apbRead(timerAddr(0, 0), rd, err);
        checkEq("masked one-shot ctrl", rd, makeCtrl(1'b0, 1'b0, 1'b0, '0));
        checkEq("hwInt with mask clear", 32'(hwInt), 32'd0);

        // External line sits right above the timers
        extInt = 1'b1;
        @(negedge clk);
        checkEq("hwInt before extInt is registered", 32'(hwInt), 32'd0);
        @(posedge clk);
        #2;
        checkEq("hwInt with extInt", 32'(hwInt), 32'd1 << `NUM_TIMERS);
        extInt = 1'b0;
        @(posedge clk);
        #2;
        checkEq("hwInt after extInt drops", 32'(hwInt), 32'd0);

        $display("=== PASS ===");
        $finish;
    end

endmodule

// ==== Makefile ====
# Verilator build and run for the south bridge testbench

VERILATOR ?= verilator
TOP       ?= tbSouthBridge
FILELIST  ?= all.f
OBJDIR    ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(shell grep -v '^+' $(FILELIST))
HEADERS := $(wildcard source/*.svh)
BIN     := $(OBJDIR)/V$(TOP)

.PHONY: all build run check clean

all: check

build: $(BIN)

# Rebuilt only when a source, header or the file list changes
$(OBJDIR)/V%: $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $* -f $(FILELIST) --Mdir $(OBJDIR)

run: $(BIN)
	./$(BIN) 2>&1 | tee $(LOG)

check: run
	@grep -q "^=== PASS ===$$" $(LOG) || { echo "Simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJDIR) $(LOG)

// ==== all.f ====
+incdir+source
source/bridgePkg.sv
source/apbDecoder.sv
source/devTimer.sv
source/returnMerge.sv
source/southBridge.sv
tb/tbSouthBridge.sv
